/* design/conv_types_pkg.sv */
package conv_types_pkg;

  ////////////////////////////////////////////////////////////////////
  // data widths

  typedef logic signed [15:0] pxl_t;
  typedef logic signed [15:0] weight_t;
  // full-width product of one pixel and one weight
  typedef logic signed [31:0] prod_t;
  // wide enough for 9 x CHANNEL_NUM_IN full-scale products
  typedef logic signed [39:0] acc_t;

  typedef logic [3:0] oc_idx_t;
  typedef logic [7:0] ic_idx_t;

  ////////////////////////////////////////////////////////////////////
  // beat and window formats

  // position tag carried with every beat
  typedef struct packed {
    oc_idx_t oc;
    ic_idx_t ic;
    logic    plane_first;
    logic    ic_last;
  } tag_t;

  typedef struct packed {
    pxl_t pxl;
    tag_t tag;
  } pxl_beat_t;

  // index r*3+c, row-major from the top-left pixel
  typedef struct packed {
    pxl_t [8:0] p;
  } window_t;

  typedef struct packed {
    weight_t [8:0] w;
  } kernel_t;

endpackage

/* design/conv_ctrl_pkg.sv */
package conv_ctrl_pkg;

  // input frame storage and replay
  typedef enum logic [1:0] {
    fill,
    wait_weights,
    replay
  } replay_state_t;

  // weight set loading
  typedef enum logic {
    load,
    ready
  } weight_state_t;

endpackage

/* design/frame_replay.sv */
`timescale 1ns/1ps

module frame_replay #(
  parameter int IMAGE_WIDTH     = 8,
  parameter int IMAGE_HEIGHT    = 8,
  parameter int CHANNEL_NUM_IN  = 3,
  parameter int CHANNEL_NUM_OUT = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      valid_in,
  input  conv_types_pkg::pxl_t      pxl_in,
  input  logic                      weights_ready,
  output logic                      beat_valid,
  output conv_types_pkg::pxl_beat_t beat
);

  localparam int PLANE = IMAGE_WIDTH * IMAGE_HEIGHT;
  localparam int FRAME = PLANE * CHANNEL_NUM_IN;
  localparam int AW    = $clog2(FRAME);
  localparam int PW    = $clog2(PLANE);

  conv_ctrl_pkg::replay_state_t state;
  conv_types_pkg::pxl_t         frame_mem [FRAME];
  logic [AW-1:0]                wr_addr;
  logic [AW-1:0]                rd_addr;
  logic [PW-1:0]                pix_cnt;
  conv_types_pkg::ic_idx_t      ic_cnt;
  conv_types_pkg::oc_idx_t      oc_cnt;
  logic                         plane_end;
  logic                         ic_end;
  logic                         oc_end;

  assign plane_end = (pix_cnt == PW'(PLANE - 1));
  assign ic_end    = (ic_cnt == conv_types_pkg::ic_idx_t'(CHANNEL_NUM_IN - 1));
  assign oc_end    = (oc_cnt == conv_types_pkg::oc_idx_t'(CHANNEL_NUM_OUT - 1));

  // pixels outside fill are dropped
  always_ff @(posedge clk) begin
    if (state == conv_ctrl_pkg::fill && valid_in) begin
      frame_mem[wr_addr] <= pxl_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fill / replay control

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= conv_ctrl_pkg::fill;
      wr_addr <= '0;
      rd_addr <= '0;
      pix_cnt <= '0;
      ic_cnt  <= '0;
      oc_cnt  <= '0;
    end else begin
      case (state)
        conv_ctrl_pkg::fill: begin
          if (valid_in) begin
            if (wr_addr == AW'(FRAME - 1)) begin
              wr_addr <= '0;
              state   <= weights_ready ? conv_ctrl_pkg::replay : conv_ctrl_pkg::wait_weights;
            end else begin
              wr_addr <= wr_addr + 1'b1;
            end
          end
        end
        conv_ctrl_pkg::wait_weights: begin
          if (weights_ready) begin
            state <= conv_ctrl_pkg::replay;
          end
        end
        default: begin
          // walk pixel, then input channel, then output channel
          pix_cnt <= plane_end ? '0 : pix_cnt + 1'b1;
          rd_addr <= (plane_end && ic_end) ? '0 : rd_addr + 1'b1;
          if (plane_end) begin
            ic_cnt <= ic_end ? '0 : ic_cnt + 1'b1;
            if (ic_end) begin
              oc_cnt <= oc_end ? '0 : oc_cnt + 1'b1;
              if (oc_end) begin
                state <= conv_ctrl_pkg::fill;
              end
            end
          end
        end
      endcase
    end
  end

  // one beat per replay cycle, no gaps
  assign beat_valid = (state == conv_ctrl_pkg::replay);

  always_comb begin
    beat.pxl             = frame_mem[rd_addr];
    beat.tag.oc          = oc_cnt;
    beat.tag.ic          = ic_cnt;
    beat.tag.plane_first = (pix_cnt == '0);
    beat.tag.ic_last     = ic_end;
  end

endmodule

/* design/weight_store.sv */
`timescale 1ns/1ps

module weight_store #(
  parameter int CHANNEL_NUM_IN  = 3,
  parameter int CHANNEL_NUM_OUT = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      valid_weight_in,
  input  conv_types_pkg::weight_t   weight_in,
  input  conv_types_pkg::oc_idx_t   oc,
  input  conv_types_pkg::ic_idx_t   ic,
  output logic                      weights_ready,
  output conv_types_pkg::kernel_t   kernel
);

  localparam int N_WEIGHTS = 9 * CHANNEL_NUM_IN * CHANNEL_NUM_OUT;
  localparam int WA        = $clog2(N_WEIGHTS);

  conv_ctrl_pkg::weight_state_t state;
  conv_types_pkg::weight_t      w_mem [N_WEIGHTS];
  logic [WA-1:0]                wr_addr;
  logic [WA-1:0]                wr_ptr;
  logic [WA-1:0]                base;

  // a strobe while ready starts the next set at entry 0
  assign wr_ptr = (state == conv_ctrl_pkg::ready) ? '0 : wr_addr;

  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      w_mem[wr_ptr] <= weight_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= conv_ctrl_pkg::load;
      wr_addr <= '0;
    end else if (valid_weight_in) begin
      if (wr_ptr == WA'(N_WEIGHTS - 1)) begin
        state   <= conv_ctrl_pkg::ready;
        wr_addr <= '0;
      end else begin
        state   <= conv_ctrl_pkg::load;
        wr_addr <= wr_ptr + 1'b1;
      end
    end
  end

  assign weights_ready = (state == conv_ctrl_pkg::ready);

  // entries ordered oc, ic, kernel position
  assign base = WA'((int'(oc) * CHANNEL_NUM_IN + int'(ic)) * 9);

  always_comb begin
    for (int k = 0; k < 9; k++) begin
      kernel.w[k] = w_mem[base + WA'(k)];
    end
  end

endmodule

/* design/line_window.sv */
`timescale 1ns/1ps

module line_window #(
  parameter int IMAGE_WIDTH  = 8,
  parameter int IMAGE_HEIGHT = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      beat_valid,
  input  conv_types_pkg::pxl_beat_t beat,
  output logic                      win_valid,
  output conv_types_pkg::window_t   window,
  output conv_types_pkg::tag_t      win_tag
);

  localparam int CW = $clog2(IMAGE_WIDTH);
  localparam int RW = $clog2(IMAGE_HEIGHT);

  logic [CW-1:0]        col_cnt;
  logic [CW-1:0]        cur_col;
  logic [RW-1:0]        row_cnt;
  logic [RW-1:0]        cur_row;
  conv_types_pkg::pxl_t line_0 [IMAGE_WIDTH];
  conv_types_pkg::pxl_t line_1 [IMAGE_WIDTH];

  // position of the incoming pixel
  assign cur_col = beat.tag.plane_first ? '0 : col_cnt;
  assign cur_row = beat.tag.plane_first ? '0 : row_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      col_cnt   <= '0;
      row_cnt   <= '0;
      win_valid <= 1'b0;
    end else begin
      // border windows are dropped, valid convolution only
      win_valid <= beat_valid && (cur_col >= CW'(2)) && (cur_row >= RW'(2));
      if (beat_valid) begin
        if (cur_col == CW'(IMAGE_WIDTH - 1)) begin
          col_cnt <= '0;
          row_cnt <= cur_row + 1'b1;
        end else begin
          col_cnt <= cur_col + 1'b1;
          row_cnt <= cur_row;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // line buffers and 3x3 window

  always_ff @(posedge clk) begin
    if (beat_valid) begin
      // line_0 end is one row up, line_1 end two rows up
      line_0[0] <= beat.pxl;
      line_1[0] <= line_0[IMAGE_WIDTH-1];
      for (int i = 1; i < IMAGE_WIDTH; i++) begin
        line_0[i] <= line_0[i-1];
        line_1[i] <= line_1[i-1];
      end

      // shift columns left, new column enters at the right
      for (int r = 0; r < 3; r++) begin
        window.p[r*3]   <= window.p[r*3+1];
        window.p[r*3+1] <= window.p[r*3+2];
      end
      window.p[2] <= line_1[IMAGE_WIDTH-1];
      window.p[5] <= line_0[IMAGE_WIDTH-1];
      window.p[8] <= beat.pxl;

      // tag of the bottom-right pixel
      win_tag <= beat.tag;
    end
  end

endmodule

/* design/window_mac.sv */
`timescale 1ns/1ps

module window_mac (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    win_valid,
  input  conv_types_pkg::window_t window,
  input  conv_types_pkg::kernel_t kernel,
  input  conv_types_pkg::tag_t    win_tag,
  output logic                    mac_valid,
  output conv_types_pkg::acc_t    mac_sum,
  output conv_types_pkg::tag_t    mac_tag
);

  conv_types_pkg::prod_t prod [9];
  conv_types_pkg::tag_t  stage1_tag;
  conv_types_pkg::acc_t  tree_sum;
  logic                  stage1_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage1_valid <= 1'b0;
      mac_valid    <= 1'b0;
    end else begin
      stage1_valid <= win_valid;
      mac_valid    <= stage1_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 1: nine signed products

  always_ff @(posedge clk) begin
    for (int k = 0; k < 9; k++) begin
      prod[k] <= $signed(window.p[k]) * $signed(kernel.w[k]);
    end
    stage1_tag <= win_tag;
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: adder tree

  always_comb begin
    conv_types_pkg::acc_t pair [4];
    for (int k = 0; k < 4; k++) begin
      pair[k] = conv_types_pkg::acc_t'(prod[2*k]) + conv_types_pkg::acc_t'(prod[2*k+1]);
    end
    tree_sum = (pair[0] + pair[1]) + (pair[2] + pair[3]) + conv_types_pkg::acc_t'(prod[8]);
  end

  always_ff @(posedge clk) begin
    mac_sum <= tree_sum;
    mac_tag <= stage1_tag;
  end

endmodule

/* design/channel_accum.sv */
`timescale 1ns/1ps

module channel_accum #(
  parameter int IMAGE_WIDTH  = 8,
  parameter int IMAGE_HEIGHT = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mac_valid,
  input  conv_types_pkg::acc_t mac_sum,
  input  conv_types_pkg::tag_t mac_tag,
  output logic                 valid_out,
  output conv_types_pkg::acc_t pxl_out
);

  localparam int OUT_PIX = (IMAGE_WIDTH - 2) * (IMAGE_HEIGHT - 2);
  localparam int BA      = $clog2(OUT_PIX);

  conv_types_pkg::acc_t acc_mem [OUT_PIX];
  conv_types_pkg::acc_t total;
  logic [BA-1:0]        addr;

  // channel 0 starts a fresh sum
  assign total = (mac_tag.ic == '0) ? mac_sum : acc_mem[addr] + mac_sum;

  // every plane gives exactly OUT_PIX windows, so the wrap
  // lines up with the start of each input channel
  always_ff @(posedge clk) begin
    if (reset) begin
      addr      <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= mac_valid && mac_tag.ic_last;
      if (mac_valid) begin
        addr <= (addr == BA'(OUT_PIX - 1)) ? '0 : addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mac_valid) begin
      if (mac_tag.ic_last) begin
        // last channel goes straight out
        pxl_out <= total;
      end else begin
        acc_mem[addr] <= total;
      end
    end
  end

endmodule

/* design/conv_layer_top.sv */
`timescale 1ns/1ps

module conv_layer_top #(
  parameter int IMAGE_WIDTH     = 8,
  parameter int IMAGE_HEIGHT    = 8,
  parameter int CHANNEL_NUM_IN  = 3,
  parameter int CHANNEL_NUM_OUT = 2
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    valid_in,
  input  conv_types_pkg::pxl_t    pxl_in,
  input  logic                    valid_weight_in,
  input  conv_types_pkg::weight_t weight_in,
  output conv_types_pkg::acc_t    pxl_out,
  output logic                    valid_out
);

  logic                      weights_ready;
  logic                      beat_valid;
  conv_types_pkg::pxl_beat_t beat;
  logic                      win_valid;
  conv_types_pkg::window_t   window;
  conv_types_pkg::tag_t      win_tag;
  conv_types_pkg::kernel_t   kernel;
  logic                      mac_valid;
  conv_types_pkg::acc_t      mac_sum;
  conv_types_pkg::tag_t      mac_tag;

  ////////////////////////////////////////////////////////////////////
  // input replay

  frame_replay #(
    .IMAGE_WIDTH    (IMAGE_WIDTH),
    .IMAGE_HEIGHT   (IMAGE_HEIGHT),
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
  ) frame_replay_i (
    .clk          (clk),
    .reset        (reset),
    .valid_in     (valid_in),
    .pxl_in       (pxl_in),
    .weights_ready(weights_ready),
    .beat_valid   (beat_valid),
    .beat         (beat)
  );

  // kernel looked up by the tag of the current window
  weight_store #(
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
  ) weight_store_i (
    .clk            (clk),
    .reset          (reset),
    .valid_weight_in(valid_weight_in),
    .weight_in      (weight_in),
    .oc             (win_tag.oc),
    .ic             (win_tag.ic),
    .weights_ready  (weights_ready),
    .kernel         (kernel)
  );

  ////////////////////////////////////////////////////////////////////
  // convolution core

  line_window #(
    .IMAGE_WIDTH (IMAGE_WIDTH),
    .IMAGE_HEIGHT(IMAGE_HEIGHT)
  ) line_window_i (
    .clk       (clk),
    .reset     (reset),
    .beat_valid(beat_valid),
    .beat      (beat),
    .win_valid (win_valid),
    .window    (window),
    .win_tag   (win_tag)
  );

  window_mac window_mac_i (
    .clk      (clk),
    .reset    (reset),
    .win_valid(win_valid),
    .window   (window),
    .kernel   (kernel),
    .win_tag  (win_tag),
    .mac_valid(mac_valid),
    .mac_sum  (mac_sum),
    .mac_tag  (mac_tag)
  );

  ////////////////////////////////////////////////////////////////////
  // sum over input channels

  channel_accum #(
    .IMAGE_WIDTH (IMAGE_WIDTH),
    .IMAGE_HEIGHT(IMAGE_HEIGHT)
  ) channel_accum_i (
    .clk      (clk),
    .reset    (reset),
    .mac_valid(mac_valid),
    .mac_sum  (mac_sum),
    .mac_tag  (mac_tag),
    .valid_out(valid_out),
    .pxl_out  (pxl_out)
  );

endmodule

/* verif/conv_layer_assert.sv */
`timescale 1ns/1ps

module conv_layer_assert #(
  parameter int RUN_LEN = 384
) (
  input logic clk,
  input logic reset,
  input logic valid_out,
  input logic beat_valid,
  input logic win_valid,
  input logic mac_valid
);

  int run_cnt;

  // length of the current replay run
  always_ff @(posedge clk) begin
    if (reset) begin
      run_cnt <= 0;
    end else if (beat_valid) begin
      run_cnt <= run_cnt + 1;
    end else begin
      run_cnt <= 0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output quiet in reset, replay run length, mac latency

  reset_quiet: assert property (@(posedge clk) reset && $past(reset) |-> !valid_out)
    else $error("valid_out high while reset is asserted");

  run_full: assert property (@(posedge clk) disable iff (reset)
    $fell(beat_valid) |-> run_cnt == RUN_LEN)
    else $error("replay run ended early, %0d beats", run_cnt);

  run_bounded: assert property (@(posedge clk) disable iff (reset)
    beat_valid |-> run_cnt < RUN_LEN)
    else $error("replay run longer than expected");

  mac_latency: assert property (@(posedge clk) disable iff (reset)
    mac_valid == $past(win_valid, 2))
    else $error("mac_valid does not follow win_valid by two cycles");

endmodule

bind conv_layer_top conv_layer_assert #(
  .RUN_LEN(CHANNEL_NUM_OUT * CHANNEL_NUM_IN * IMAGE_WIDTH * IMAGE_HEIGHT)
) conv_layer_assert_i (
  .clk       (clk),
  .reset     (reset),
  .valid_out (valid_out),
  .beat_valid(beat_valid),
  .win_valid (win_valid),
  .mac_valid (mac_valid)
);

/* verif/conv_layer_tb.sv */
`timescale 1ns/1ps

module conv_layer_tb;

  localparam int IMAGE_WIDTH     = 8;
  localparam int IMAGE_HEIGHT    = 8;
  localparam int CHANNEL_NUM_IN  = 3;
  localparam int CHANNEL_NUM_OUT = 2;
  localparam int OUT_W           = IMAGE_WIDTH - 2;
  localparam int OUT_H           = IMAGE_HEIGHT - 2;
  localparam int TIMEOUT         = 1000;

  logic                    clk;
  logic                    reset;
  logic                    valid_in;
  conv_types_pkg::pxl_t    pxl_in;
  logic                    valid_weight_in;
  conv_types_pkg::weight_t weight_in;
  conv_types_pkg::acc_t    pxl_out;
  logic                    valid_out;

  integer seed;
  int     pix [CHANNEL_NUM_IN][IMAGE_HEIGHT][IMAGE_WIDTH];
  int     wts [CHANNEL_NUM_OUT][CHANNEL_NUM_IN][9];
  longint expected [CHANNEL_NUM_OUT][OUT_H][OUT_W];

  conv_layer_top conv_layer_top_i (
    .clk            (clk),
    .reset          (reset),
    .valid_in       (valid_in),
    .pxl_in         (pxl_in),
    .valid_weight_in(valid_weight_in),
    .weight_in      (weight_in),
    .pxl_out        (pxl_out),
    .valid_out      (valid_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // signed 16-bit value from the seeded generator
  function automatic int random_value();
    int r;
    r = $random(seed);
    return int'($signed(r[15:0]));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model in oc, ic, kernel position weight order

  task automatic reference_model();
    longint sum;
    foreach (expected[oc, oy, ox]) begin
      sum = 0;
      for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
        for (int k = 0; k < 9; k++) begin
          sum += longint'(pix[ic][oy + k / 3][ox + k % 3]) * longint'(wts[oc][ic][k]);
        end
      end
      expected[oc][oy][ox] = sum;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and response

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) begin
      @(posedge clk);
      #1;
      assert (!valid_out) else fail_run("valid_out went high during reset");
    end
    reset = 1'b0;
  endtask

  task automatic load_weights(input string name);
    foreach (wts[oc, ic, k]) begin
      @(posedge clk);
      #1;
      assert (!valid_out) else fail_run($sformatf("%s: valid_out during weight load", name));
      valid_weight_in = 1'b1;
      weight_in       = conv_types_pkg::weight_t'(wts[oc][ic][k]);
    end
    @(posedge clk);
    #1;
    valid_weight_in = 1'b0;
  endtask

  // channel planes one after another in raster order
  task automatic stream_frame(input string name);
    foreach (pix[ic, y, x]) begin
      @(posedge clk);
      #1;
      assert (!valid_out) else fail_run($sformatf("%s: valid_out before frame complete", name));
      valid_in = 1'b1;
      pxl_in   = conv_types_pkg::pxl_t'(pix[ic][y][x]);
    end
    @(posedge clk);
    #1;
    valid_in = 1'b0;
  endtask

  task automatic collect_outputs(input string name);
    int     cycles;
    longint actual;
    foreach (expected[oc, oy, ox]) begin
      cycles = 0;
      do begin
        @(posedge clk);
        #1;
        cycles++;
      end while (!valid_out && cycles < TIMEOUT);
      assert (valid_out) else
        fail_run($sformatf("%s: no output for oc %0d row %0d col %0d in time", name, oc, oy, ox));
      actual = longint'(pxl_out);
      assert (actual == expected[oc][oy][ox]) else
        fail_run($sformatf("mismatch %s oc %0d row %0d col %0d: expected %0d actual %0d",
                           name, oc, oy, ox, expected[oc][oy][ox], actual));
    end
  endtask

  // no output pulse for the given number of cycles
  task automatic check_quiet(input string name, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      assert (!valid_out) else
        fail_run($sformatf("%s: valid_out pulse while no output is due", name));
    end
  endtask

  task automatic run_frame(input string name);
    load_weights(name);
    stream_frame(name);
    collect_outputs(name);
    check_quiet(name, 50);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic all_ones_test();
    foreach (pix[ic, y, x]) pix[ic][y][x] = 1;
    foreach (wts[oc, ic, k]) wts[oc][ic][k] = 1;
    foreach (expected[oc, oy, ox]) expected[oc][oy][ox] = 9 * CHANNEL_NUM_IN;
    // frame goes in first and the replay has to wait for the weights
    stream_frame("all_ones");
    check_quiet("all_ones", 200);
    load_weights("all_ones");
    collect_outputs("all_ones");
    check_quiet("all_ones", 50);
  endtask

  // center tap picks the pixel one row and one column in
  task automatic center_tap_test();
    foreach (pix[ic, y, x]) pix[ic][y][x] = random_value();
    foreach (wts[oc, ic, k]) wts[oc][ic][k] = (k == 4) ? 1 : 0;
    foreach (expected[oc, oy, ox]) begin
      expected[oc][oy][ox] = 0;
      for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
        expected[oc][oy][ox] += pix[ic][oy + 1][ox + 1];
      end
    end
    run_frame("center_tap");
  endtask

  task automatic random_data_test();
    foreach (pix[ic, y, x]) pix[ic][y][x] = random_value();
    foreach (wts[oc, ic, k]) wts[oc][ic][k] = random_value();
    reference_model();
    run_frame("random_data");
  endtask

  // same image with a fresh weight set
  task automatic second_frame_test();
    foreach (wts[oc, ic, k]) wts[oc][ic][k] = random_value();
    reference_model();
    run_frame("second_frame");
  endtask

  initial begin
    seed            = 12;
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    apply_reset();
    all_ones_test();
    center_tap_test();
    random_data_test();
    second_frame_test();
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* conv_layer_top.f */
design/conv_types_pkg.sv
design/conv_ctrl_pkg.sv
design/frame_replay.sv
design/weight_store.sv
design/line_window.sv
design/window_mac.sv
design/channel_accum.sv
design/conv_layer_top.sv
verif/conv_layer_assert.sv
verif/conv_layer_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_layer_tb -f conv_layer_top.f
./obj_dir/Vconv_layer_tb | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
